//--- hdl/sld_byte_shift.sv
////////////////////
// byte shift stage
// forms the slid chunk from the low and high source chunks
////////////////////
`timescale 1ns/10ps
`default_nettype none

module sld_byte_shift import sld_pkg::*; #(
    parameter int unsigned OP_W = OP_W_DEF
) (
    input  wire logic            clk_i,
    input  wire logic            async_rst_ni,
    input  wire logic            valid_i,
    input  wire sld_chunk_ctrl_t ctrl_i,
    input  wire logic [OP_W-1:0] lo_i,
    input  wire logic [OP_W-1:0] hi_i,
    output logic                 valid_o,
    output sld_chunk_ctrl_t      ctrl_o,
    output logic [OP_W-1:0]      res_o,
    output logic [OP_W/8-1:0]    src_be_o
);

    localparam int unsigned NB = OP_W / 8;

    logic [2*OP_W-1:0]    win;
    logic [NB-1:0][7:0]   res_d;
    logic [NB-1:0]        be_d;
    logic                 valid_q;
    sld_chunk_ctrl_t      ctrl_q;
    logic [NB-1:0][7:0]   res_q;
    logic [NB-1:0]        be_q;

    assign win = {hi_i, lo_i};

    // up reads NB-shift bytes into the window, down reads shift bytes in
    always_comb begin
        int unsigned shamt;
        int unsigned idx;
        shamt = (ctrl_i.op.dir == SLD_UP) ? NB - ctrl_i.shift_bytes : ctrl_i.shift_bytes;
        for (int i = 0; i < NB; i++) begin
            idx      = i + shamt;
            res_d[i] = win[idx*8 +: 8];
            if (ctrl_i.op.dir == SLD_DOWN) begin
                be_d[i] = 1'b1;                  // down fills with zeros, still written
            end else begin
                be_d[i] = (idx >= NB) ? ctrl_i.hi_valid : ctrl_i.lo_valid;
            end
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            ctrl_q <= ctrl_i;
            res_q  <= res_d;
            be_q   <= be_d;
        end
    end

    assign valid_o  = valid_q;
    assign ctrl_o   = ctrl_q;
    assign res_o    = res_q;
    assign src_be_o = be_q;

endmodule

`default_nettype wire

//--- hdl/sld_chunk_counter.sv
////////////////////
// chunk counter
// steps through destination chunks and locates their source chunks
////////////////////
`timescale 1ns/10ps
`default_nettype none

module sld_chunk_counter import sld_pkg::*; #(
    parameter int unsigned VREG_W = VREG_W_DEF,
    parameter int unsigned OP_W   = OP_W_DEF
) (
    input  wire logic              clk_i,
    input  wire logic              async_rst_ni,
    input  wire logic              start_i,
    input  wire logic              run_i,
    input  wire sld_op_t           op_i,
    input  wire logic [VREG_B-1:0] mask_i,
    output logic                   last_o,
    output sld_chunk_ctrl_t        ctrl_o,
    output logic                   valid_o
);

    localparam int NCH = VREG_W / OP_W;
    localparam logic [CHUNK_W-1:0] LAST_CHUNK = CHUNK_W'(NCH - 1);

    logic [CHUNK_W-1:0]        count_q;
    logic [VREG_B-1:0]         mask_q;
    logic [BOFF_W-1:0]         boff;
    logic signed [CHUNK_W+2:0] lo_idx;
    logic signed [CHUNK_W+2:0] hi_idx;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            count_q <= '0;
        end else if (start_i) begin
            count_q <= '0;
        end else if (run_i) begin
            count_q <= count_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            mask_q <= mask_i;                // mask only valid in the ack cycle
        end
    end

    assign boff   = sld_byte_offset(op_i);
    assign lo_idx = sld_lo_chunk(op_i, count_q);
    assign hi_idx = lo_idx + 1;

    assign last_o  = run_i & (count_q == LAST_CHUNK);
    assign valid_o = run_i;

    always_comb begin
        ctrl_o.op          = op_i;
        ctrl_o.chunk       = count_q;
        ctrl_o.last        = last_o;
        ctrl_o.lo_valid    = (lo_idx >= 0) && (lo_idx < NCH);
        ctrl_o.hi_valid    = (hi_idx >= 0) && (hi_idx < NCH);
        ctrl_o.shift_bytes = boff[SHIFT_W-1:0];  // whole chunks are in lo_idx
        ctrl_o.mask_bits   = mask_q;
    end

    // the last chunk ends the run unless the next op was taken with it
    a_stop_after_last : assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        run_i && last_o && !start_i |=> !run_i);

endmodule

`default_nettype wire

//--- hdl/sld_ctrl.sv
////////////////////
// slide controller
// accepts one operation at a time and runs the chunk sequence
////////////////////
`timescale 1ns/10ps
`default_nettype none

module sld_ctrl import sld_pkg::*; (
    input  wire logic    clk_i,
    input  wire logic    async_rst_ni,
    input  wire logic    op_rdy_i,
    input  wire sld_op_t op_i,
    input  wire logic    last_i,
    output logic         op_ack_o,
    output logic         start_o,
    output logic         run_o,
    output sld_op_t      op_q_o
);

    sld_state_e state_q;
    sld_op_t    op_q;

    // take a new op while idle, or overlap it with the final chunk
    assign op_ack_o = op_rdy_i & ((state_q == SLD_IDLE) | last_i);
    assign start_o  = op_ack_o;              // restarts the chunk count
    assign run_o    = (state_q == SLD_RUN);
    assign op_q_o   = op_q;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            state_q <= SLD_IDLE;
        end else if (op_ack_o) begin
            state_q <= SLD_RUN;
        end else if (last_i) begin
            state_q <= SLD_IDLE;             // sequence done, nothing waiting
        end
    end

    always_ff @(posedge clk_i) begin
        if (op_ack_o) begin
            op_q <= op_i;
        end
    end

    // the counter flags its last chunk only while a run is on
    a_last_in_run : assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        last_i |-> run_o);

endmodule

`default_nettype wire

//--- hdl/sld_operand_fetch.sv
////////////////////
// operand fetch
// keeps the source register and picks the two chunks per destination chunk
////////////////////
`timescale 1ns/10ps
`default_nettype none

module sld_operand_fetch import sld_pkg::*; #(
    parameter int unsigned VREG_W = VREG_W_DEF,
    parameter int unsigned OP_W   = OP_W_DEF
) (
    input  wire logic              clk_i,
    input  wire logic              async_rst_ni,
    input  wire logic              load_i,
    input  wire logic [VREG_W-1:0] src_i,
    input  wire logic              valid_i,
    input  wire sld_chunk_ctrl_t   ctrl_i,
    output logic                   valid_o,
    output sld_chunk_ctrl_t        ctrl_o,
    output logic [OP_W-1:0]        lo_o,
    output logic [OP_W-1:0]        hi_o
);

    localparam int unsigned NCH = VREG_W / OP_W;

    logic [NCH-1:0][OP_W-1:0]  src_q;   // first stage, filled at ack
    logic signed [CHUNK_W+2:0] lo_idx;
    logic signed [CHUNK_W+2:0] hi_idx;

    //////////////////// source register

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            src_q <= src_i;
        end
    end

    //////////////////// chunk select

    // overlap is safe: the chunk issued with the next ack still reads the old source
    assign lo_idx = sld_lo_chunk(ctrl_i.op, ctrl_i.chunk);
    assign hi_idx = lo_idx + 1;

    assign lo_o = ctrl_i.lo_valid ? src_q[lo_idx[CHUNK_W-1:0]] : '0;  // zero outside register
    assign hi_o = ctrl_i.hi_valid ? src_q[hi_idx[CHUNK_W-1:0]] : '0;

    assign valid_o = valid_i;
    assign ctrl_o  = ctrl_i;

    // chunk 0 of an op always follows its load by one cycle
    a_issue_after_load : assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        load_i |=> valid_i && (ctrl_i.chunk == '0));

endmodule

`default_nettype wire

//--- hdl/sld_pkg.sv
////////////////////
// slide unit shared types
// widths, enums and the per-chunk control word
////////////////////
`default_nettype none

package sld_pkg;

    localparam int unsigned VREG_W_DEF = 128;               // vector register width
    localparam int unsigned OP_W_DEF   = 32;                // chunk width

    localparam int unsigned VREG_B  = VREG_W_DEF / 8;       // bytes per register
    localparam int unsigned CHUNK_W = $clog2(VREG_W_DEF / OP_W_DEF);
    localparam int unsigned SHIFT_W = $clog2(OP_W_DEF / 8);
    localparam int unsigned BOFF_W  = $clog2(VREG_B) + 1;   // byte offset, 0 to VREG_B

    typedef enum logic [1:0] {EEW_8, EEW_16, EEW_32} sld_eew_e;
    typedef enum logic {SLD_UP, SLD_DOWN} sld_dir_e;
    typedef enum logic {SLD_IDLE, SLD_RUN} sld_state_e;

    typedef struct packed {
        sld_dir_e   dir;
        sld_eew_e   eew;
        logic       masked;
        logic [4:0] vl;          // elements, 0 to 16
        logic [7:0] offset;      // elements
    } sld_op_t;

    typedef struct packed {
        sld_op_t             op;
        logic [CHUNK_W-1:0]  chunk;
        logic                last;
        logic                lo_valid;
        logic                hi_valid;
        logic [SHIFT_W-1:0]  shift_bytes;
        logic [VREG_B-1:0]   mask_bits;
    } sld_chunk_ctrl_t;

    // element offset scaled to bytes, saturated at one full register
    function automatic logic [BOFF_W-1:0] sld_byte_offset(sld_op_t op);
        logic [9:0] b;
        b = {2'b00, op.offset} << op.eew;
        return (b >= 10'(VREG_B)) ? BOFF_W'(VREG_B) : b[BOFF_W-1:0];
    endfunction

    // index of the lower source chunk feeding destination chunk, may lie outside
    function automatic logic signed [CHUNK_W+2:0] sld_lo_chunk(sld_op_t op,
                                                              logic [CHUNK_W-1:0] chunk);
        logic signed [CHUNK_W+2:0] k;
        logic signed [CHUNK_W+2:0] wc;
        k  = $signed({3'b000, chunk});
        wc = $signed((CHUNK_W + 3)'(sld_byte_offset(op) >> SHIFT_W));
        return (op.dir == SLD_UP) ? k - wc - 1 : k + wc;
    endfunction

endpackage

`default_nettype wire

//--- hdl/sld_unit.sv
////////////////////
// vector slide unit
// slide up/down of one register, written back in chunks
////////////////////
`timescale 1ns/10ps
`default_nettype none

module sld_unit import sld_pkg::*; #(
    parameter int unsigned VREG_W = VREG_W_DEF,
    parameter int unsigned OP_W   = OP_W_DEF
) (
    input  wire logic              clk_i,
    input  wire logic              async_rst_ni,
    input  wire logic              op_rdy_i,
    input  wire sld_op_t           op_i,
    input  wire logic [VREG_W-1:0] src_i,
    input  wire logic [VREG_B-1:0] mask_i,
    output logic                   op_ack_o,
    output logic                   wr_en_o,
    output logic [CHUNK_W-1:0]     wr_chunk_o,
    output logic [OP_W-1:0]        wr_data_o,
    output logic [OP_W/8-1:0]      wr_be_o,
    output logic                   done_o
);

    sld_op_t           op_q;
    logic              start;
    logic              run;
    logic              last;
    logic              cnt_valid, fch_valid, sft_valid;
    sld_chunk_ctrl_t   cnt_ctrl, fch_ctrl, sft_ctrl;
    logic [OP_W-1:0]   lo, hi;                  // source chunks
    logic [OP_W-1:0]   res;
    logic [OP_W/8-1:0] src_be;

    sld_ctrl u_ctrl (
        .clk_i, .async_rst_ni, .op_rdy_i, .op_i,
        .last_i   (last),
        .op_ack_o,
        .start_o  (start),
        .run_o    (run),
        .op_q_o   (op_q)
    );

    sld_chunk_counter #(.VREG_W(VREG_W), .OP_W(OP_W)) u_counter (
        .clk_i, .async_rst_ni,
        .start_i  (start),
        .run_i    (run),
        .op_i     (op_q),
        .mask_i,
        .last_o   (last),
        .ctrl_o   (cnt_ctrl),
        .valid_o  (cnt_valid)
    );

    sld_operand_fetch #(.VREG_W(VREG_W), .OP_W(OP_W)) u_fetch (
        .clk_i, .async_rst_ni,
        .load_i   (op_ack_o),
        .src_i,
        .valid_i  (cnt_valid),
        .ctrl_i   (cnt_ctrl),
        .valid_o  (fch_valid),
        .ctrl_o   (fch_ctrl),
        .lo_o     (lo),
        .hi_o     (hi)
    );

    sld_byte_shift #(.OP_W(OP_W)) u_shift (
        .clk_i, .async_rst_ni,
        .valid_i  (fch_valid),
        .ctrl_i   (fch_ctrl),
        .lo_i     (lo),
        .hi_i     (hi),
        .valid_o  (sft_valid),
        .ctrl_o   (sft_ctrl),
        .res_o    (res),
        .src_be_o (src_be)
    );

    sld_write_mask #(.OP_W(OP_W)) u_wmask (
        .clk_i, .async_rst_ni,
        .valid_i  (sft_valid),
        .ctrl_i   (sft_ctrl),
        .res_i    (res),
        .src_be_i (src_be),
        .wr_en_o, .wr_chunk_o, .wr_data_o, .wr_be_o, .done_o
    );

endmodule

`default_nettype wire

//--- hdl/sld_write_mask.sv
////////////////////
// write mask stage
// applies vl and element mask, drives the register write port
////////////////////
`timescale 1ns/10ps
`default_nettype none

module sld_write_mask import sld_pkg::*; #(
    parameter int unsigned OP_W = OP_W_DEF
) (
    input  wire logic              clk_i,
    input  wire logic              async_rst_ni,
    input  wire logic              valid_i,
    input  wire sld_chunk_ctrl_t   ctrl_i,
    input  wire logic [OP_W-1:0]   res_i,
    input  wire logic [OP_W/8-1:0] src_be_i,
    output logic                   wr_en_o,
    output logic [CHUNK_W-1:0]     wr_chunk_o,
    output logic [OP_W-1:0]        wr_data_o,
    output logic [OP_W/8-1:0]      wr_be_o,
    output logic                   done_o
);

    localparam int unsigned NB = OP_W / 8;

    logic [NB-1:0][7:0] data_d;
    logic [NB-1:0]      be_d;

    always_comb begin
        logic [7:0]  vl_bytes;
        int unsigned j;
        vl_bytes = {3'b000, ctrl_i.op.vl} << ctrl_i.op.eew;
        for (int i = 0; i < NB; i++) begin
            j       = int'(ctrl_i.chunk) * NB + i;   // byte index in register
            be_d[i] = src_be_i[i] & (j < vl_bytes) &
                      (!ctrl_i.op.masked | ctrl_i.mask_bits[j >> ctrl_i.op.eew]);
            data_d[i] = be_d[i] ? res_i[i*8 +: 8] : 8'h00;
        end
    end

    //////////////////// write port

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            wr_en_o <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            wr_en_o <= valid_i;
            done_o  <= valid_i & ctrl_i.last;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            wr_chunk_o <= ctrl_i.chunk;
            wr_data_o  <= data_d;
            wr_be_o    <= be_d;
        end
    end

    // done closes a burst, so a write sits before it too
    a_done_in_burst : assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        done_o |-> wr_en_o && $past(wr_en_o));

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the slide unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_sld --Mdir obj_dir -o tb_sld_sim

./obj_dir/tb_sld_sim 2>&1 | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
    exit 0
else
    exit 1
fi

//--- sim/sld_checker.sv
////////////////////
// slide unit checker
// compares each chunk write with the queued expectation
////////////////////
`timescale 1ns/10ps
`default_nettype none

module sld_checker import sld_pkg::*; (
    input  wire logic                  clk_i,
    input  wire logic                  async_rst_ni,
    input  wire logic                  op_ack_i,
    input  wire logic                  wr_en_i,
    input  wire logic [CHUNK_W-1:0]    wr_chunk_i,
    input  wire logic [OP_W_DEF-1:0]   wr_data_i,
    input  wire logic [OP_W_DEF/8-1:0] wr_be_i,
    input  wire logic                  done_i
);

    localparam int NCHUNK  = VREG_W_DEF / OP_W_DEF;
    localparam int LATENCY = 3;                  // ack to chunk 0 write

    typedef struct packed {
        logic [CHUNK_W-1:0]    chunk;
        logic [OP_W_DEF-1:0]   data;
        logic [OP_W_DEF/8-1:0] be;
    } wr_exp_t;

    wr_exp_t exp_q[$];
    int      ack_q[$];                           // cycle of each ack
    int      cycle       = 0;
    int      n_writes    = 0;
    int      n_val_err   = 0;
    int      n_other_err = 0;

    task automatic push_expect(input logic [CHUNK_W-1:0] chunk,
                               input logic [OP_W_DEF-1:0] data,
                               input logic [OP_W_DEF/8-1:0] be);
        exp_q.push_back('{chunk: chunk, data: data, be: be});
    endtask

    function automatic int pending_count();
        return exp_q.size();
    endfunction

    task automatic note_failure(input string msg);
        $display("error at %0t: %s", $time, msg);
        n_other_err++;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s write %0d: got %0h, expected %0h", name, n_writes, got, exp);
            n_val_err++;
        end
    endtask

    //////////////////// write port monitor

    // outputs are stable at the falling edge
    always @(negedge clk_i) begin
        wr_exp_t e;
        int      lat;
        if (async_rst_ni) begin
            cycle++;
            if (op_ack_i) begin
                ack_q.push_back(cycle);
            end
            if (wr_en_i) begin
                n_writes++;
                if (exp_q.size() == 0) begin
                    note_failure($sformatf("unexpected write to chunk %0d", wr_chunk_i));
                end else begin
                    e = exp_q.pop_front();
                    check_value("wr_chunk_o", wr_chunk_i, e.chunk);
                    check_value("wr_data_o", wr_data_i, e.data);
                    check_value("wr_be_o", wr_be_i, e.be);
                    check_value("done_o", done_i, e.chunk == CHUNK_W'(NCHUNK - 1));
                end
                if (wr_chunk_i == '0) begin
                    if (ack_q.size() == 0) begin
                        note_failure("chunk 0 written without an earlier op_ack_o");
                    end else begin
                        lat = cycle - ack_q.pop_front();
                        if (lat != LATENCY) begin
                            note_failure($sformatf("chunk 0 came %0d cycles after op_ack_o, not %0d",
                                                   lat, LATENCY));
                        end
                    end
                end
            end else if (done_i) begin
                note_failure("done_o high without a write");
            end
        end
    end

    task automatic report(output int total);
        if (exp_q.size() != 0) begin
            note_failure($sformatf("%0d expected writes never arrived", exp_q.size()));
        end
        $display("checker: %0d writes, %0d value errors, %0d other errors",
                 n_writes, n_val_err, n_other_err);
        total = n_val_err + n_other_err;
    endtask

endmodule

`default_nettype wire

//--- sim/sld_input.txt
# op line: dir (0 up, 1 down) eew_bits vl offset masked mask_hex src_hex, vl and offset decimal
# then one line per chunk: chunk data_hex be_hex
0 8 16 5 0 0000 1f1e1d1c1b1a19181716151413121110
0 00000000 0
1 12111000 e
2 16151413 f
3 1a191817 f
0 16 6 3 1 00eb 2f2e2d2c2b2a29282726252423222120
0 00000000 0
1 21200000 c
2 25240000 c
3 00000000 0
0 32 4 1 0 0000 3f3e3d3c3b3a39383736353433323130
0 00000000 0
1 33323130 f
2 37363534 f
3 3b3a3938 f
1 8 16 6 0 5555 4f4e4d4c4b4a49484746454443424140
0 49484746 f
1 4d4c4b4a f
2 00004f4e f
3 00000000 f
1 16 0 1 0 0000 5f5e5d5c5b5a59585756555453525150
0 00000000 0
1 00000000 0
2 00000000 0
3 00000000 0
1 32 3 1 1 000d 6f6e6d6c6b6a69686766656463626160
0 67666564 f
1 00000000 0
2 6f6e6d6c f
3 00000000 0
0 8 16 20 0 0000 7f7e7d7c7b7a79787776757473727170
0 00000000 0
1 00000000 0
2 00000000 0
3 00000000 0
1 16 8 200 0 0000 8f8e8d8c8b8a89888786858483828180
0 00000000 f
1 00000000 f
2 00000000 f
3 00000000 f

//--- sim/tb_sld.sv
////////////////////
// slide unit testbench
// drives file operations with idle gaps and back-to-back runs
////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_sld import sld_pkg::*; ();

    localparam int NCHUNK        = VREG_W_DEF / OP_W_DEF;
    localparam int ACK_TIMEOUT   = 16;   // a full burst plus margin
    localparam int DRAIN_TIMEOUT = 32;

    logic                    clk_i;
    logic                    async_rst_ni;
    logic                    op_rdy_i;
    sld_op_t                 op_i;
    logic [VREG_W_DEF-1:0]   src_i;
    logic [VREG_B-1:0]       mask_i;
    logic                    op_ack_o;
    logic                    wr_en_o;
    logic [CHUNK_W-1:0]      wr_chunk_o;
    logic [OP_W_DEF-1:0]     wr_data_o;
    logic [OP_W_DEF/8-1:0]   wr_be_o;
    logic                    done_o;

    int          fd;
    bit          timed_out;
    int          total_err;

    sld_unit #(.VREG_W(VREG_W_DEF), .OP_W(OP_W_DEF)) sld_unit_i (
        .clk_i, .async_rst_ni, .op_rdy_i, .op_i, .src_i, .mask_i,
        .op_ack_o, .wr_en_o, .wr_chunk_o, .wr_data_o, .wr_be_o, .done_o
    );

    sld_checker u_checker (
        .clk_i, .async_rst_ni,
        .op_ack_i   (op_ack_o),
        .wr_en_i    (wr_en_o),
        .wr_chunk_i (wr_chunk_o),
        .wr_data_i  (wr_data_o),
        .wr_be_i    (wr_be_o),
        .done_i     (done_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    //////////////////// file reading

    // next line that is not a comment, ok low at end of file
    task automatic next_line(output string line, output bit ok);
        int n;
        ok   = 1'b0;
        line = "";
        while (!ok && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != 8'h23) begin   // 8'h23 is '#'
                ok = 1'b1;
            end
        end
    endtask

    // the chunk writes listed under an operation go to the checker
    task automatic load_expects(output bit ok);
        string                 line;
        bit                    got;
        int                    chunk;
        logic [OP_W_DEF-1:0]   data;
        logic [OP_W_DEF/8-1:0] be;
        ok = 1'b1;
        for (int k = 0; k < NCHUNK && ok; k++) begin
            next_line(line, got);
            if (!got || $sscanf(line, "%d %h %h", chunk, data, be) != 3) begin
                ok = 1'b0;
            end else begin
                u_checker.push_expect(chunk[CHUNK_W-1:0], data, be);
            end
        end
    endtask

    //////////////////// stimulus

    // hold the op on the bus until the unit takes it
    task automatic issue_op(input sld_op_t op, input logic [VREG_W_DEF-1:0] src,
                            input logic [VREG_B-1:0] mask, output int ack_wait);
        int waited;
        op_i     = op;
        src_i    = src;
        mask_i   = mask;
        op_rdy_i = 1'b1;
        waited   = 0;
        @(negedge clk_i);
        while (!op_ack_o && waited < ACK_TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (!op_ack_o) begin
            timed_out = 1'b1;
            u_checker.note_failure($sformatf("no op_ack_o within %0d cycles", ACK_TIMEOUT));
        end
        ack_wait = waited;
        @(posedge clk_i);
        #1;
    endtask

    initial begin
        string                 line;
        bit                    more;
        bit                    ok;
        int                    n_ops;
        int                    dir, eew_bits, vl, offset, masked;
        logic [VREG_B-1:0]     mask;
        logic [VREG_W_DEF-1:0] src;
        sld_op_t               op;
        int unsigned           gap;
        int                    waited;
        int                    ack_wait;

        void'($urandom(32'hcd5b));
        async_rst_ni = 1'b0;
        op_rdy_i     = 1'b0;
        op_i         = '0;
        src_i        = '0;
        mask_i       = '0;
        timed_out    = 1'b0;
        n_ops        = 0;
        repeat (16) @(posedge clk_i);
        #1;
        async_rst_ni = 1'b1;

        fd = $fopen("sim/sld_input.txt", "r");
        if (fd == 0) begin
            u_checker.note_failure("cannot open sim/sld_input.txt");
        end
        more = (fd != 0);
        while (more && !timed_out) begin
            next_line(line, more);
            if (more) begin
                if ($sscanf(line, "%d %d %d %d %d %h %h",
                            dir, eew_bits, vl, offset, masked, mask, src) != 7) begin
                    u_checker.note_failure($sformatf("bad operation line after op %0d", n_ops));
                    more = 1'b0;
                end else begin
                    load_expects(ok);
                    if (!ok) begin
                        u_checker.note_failure($sformatf("missing chunk lines for op %0d", n_ops));
                        more = 1'b0;
                    end else begin
                        op        = '0;
                        op.dir    = (dir != 0) ? SLD_DOWN : SLD_UP;
                        op.eew    = (eew_bits == 8) ? EEW_8 : (eew_bits == 16) ? EEW_16 : EEW_32;
                        op.masked = masked[0];
                        op.vl     = vl[4:0];
                        op.offset = offset[7:0];
                        if (n_ops % 2 == 0) begin        // odd ops follow back-to-back
                            op_rdy_i = 1'b0;
                            gap      = 1 + ($urandom % 3);
                            repeat (gap) @(posedge clk_i);
                            #1;
                        end
                        issue_op(op, src, mask, ack_wait);
                        // held ready, the op goes in with the last chunk of the one before
                        if (n_ops % 2 == 1 && !timed_out && ack_wait != NCHUNK - 1) begin
                            u_checker.note_failure($sformatf(
                                "op %0d waited %0d cycles for op_ack_o, not %0d",
                                n_ops, ack_wait, NCHUNK - 1));
                        end
                        n_ops++;
                    end
                end
            end
        end
        op_rdy_i = 1'b0;
        if (fd != 0) begin
            $fclose(fd);
        end
        if (n_ops == 0) begin
            u_checker.note_failure("no operation was run");
        end

        waited = 0;
        while (!timed_out && u_checker.pending_count() != 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        repeat (4) @(negedge clk_i);             // room for a stray write
        u_checker.report(total_err);
        if (total_err == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
hdl/sld_pkg.sv
hdl/sld_ctrl.sv
hdl/sld_chunk_counter.sv
hdl/sld_operand_fetch.sv
hdl/sld_byte_shift.sv
hdl/sld_write_mask.sv
hdl/sld_unit.sv
sim/sld_checker.sv
sim/tb_sld.sv
